// ==== compile.f ====
source/rackbus_pkg.sv
source/surf_pkg.sv
source/cmd_holding.sv
source/reg_bank.sv
source/rack_register_core.sv
bench/tb_clock.sv
bench/tb_rack_register_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tb_rack_register_core
RTL_TOP    := rack_register_core
FILELIST   := compile.f
RTL_SRCS   := source/rackbus_pkg.sv source/surf_pkg.sv source/cmd_holding.sv \
              source/reg_bank.sv source/rack_register_core.sv
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_rack_register_core.sv ====
`timescale 1ns/1ps

module tb_rack_register_core
    import rackbus_pkg::*, surf_pkg::*;
();

    // well above the cycle count of all five tests together
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int WRITE_ROUNDS   = 24;
    localparam int STATUS_ROUNDS  = 8;
    localparam logic [5:0] WRITE_ADDRS [5] = '{CONTROL, LIVE, TRAININ, TRAINCMPL, COUTCTRL};
    localparam logic [5:0] READ_ADDRS [10] = '{6'h00, 6'h04, 6'h08, 6'h0C, 6'h10,
                                               6'h14, 6'h18, 6'h1C, 6'h20, 6'h24};

    logic                   wb_clk;
    logic                   reset;
    wb_req_t                bus;
    surf_status_t           status;
    logic                   runcmd_tready;
    logic                   trig_tready;
    logic                   ack;
    logic [31:0]            rdat;
    logic                   runcmd_tvalid;
    logic [RUNCMD_BITS-1:0] runcmd_tdata;
    logic                   trig_tvalid;
    logic [TRIG_BITS-1:0]   trig_tdata;
    logic                   event_reset;
    logic                   livedet_reset;
    logic [7:0]             disable_rxclk;
    logic [3:0]             cout_offset;
    surf_mask_t             train_complete;
    surf_mask_t             autotrain_en;

    // shadow copy of every register word the host can write
    logic [31:0]            ctrl_w, live_w, trainin_w, traincmpl_w, cout_w;
    logic                   runcmd_pend, trig_pend;
    logic [RUNCMD_BITS-1:0] runcmd_last;
    logic [TRIG_BITS-1:0]   trig_last;

    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    time         time_q[$];
    int          check_count, error_count, test_errors, cycle_count;
    int          runcmd_xfers, trig_xfers;

    tb_clock u_clock (
        .clk_o   (wb_clk),
        .reset_o (reset)
    );

    rack_register_core uut (
        .wb_clk_i            (wb_clk),
        .reset_i             (reset),
        .bus_i               (bus),
        .status_i            (status),
        .runcmd_tready_i     (runcmd_tready),
        .trig_tready_i       (trig_tready),
        .ack_o               (ack),
        .rdat_o              (rdat),
        .runcmd_tvalid_o     (runcmd_tvalid),
        .runcmd_tdata_o      (runcmd_tdata),
        .trig_tvalid_o       (trig_tvalid),
        .trig_tdata_o        (trig_tdata),
        .event_reset_o       (event_reset),
        .livedet_reset_o     (livedet_reset),
        .disable_rxclk_o     (disable_rxclk),
        .cout_offset_o       (cout_offset),
        .train_complete_o    (train_complete),
        .surf_autotrain_en_o (autotrain_en)
    );

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w, wdat,
                                                input logic [3:0] sel);
        logic [31:0] w;
        w = old_w;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                w[8*i +: 8] = wdat[8*i +: 8];
            end
        end
        return w;
    endfunction

    // readback word as the register map describes it
    function automatic logic [31:0] expected_read(input logic [5:0] off);
        logic [31:0] w;
        w = '0;
        case (off)
            CONTROL: begin
                w[31:24] = ctrl_w[31:24];
                w[16]    = ctrl_w[16];
                w[3]     = !trig_pend;
                w[2]     = !runcmd_pend;
            end
            LIVE: begin
                w[31]    = live_w[31];
                w[22:16] = status.misaligned;
                w[6:0]   = status.live;
            end
            TRAININ: begin
                w[22:16] = trainin_w[22:16];
                w[6:0]   = status.trainin_req;
            end
            TRAINOUT:  w[6:0] = status.trainout_rdy;
            TRAINCMPL: begin
                w[22:16] = status.boot_seen;
                w[6:0]   = traincmpl_w[6:0];
            end
            COUTCTRL:  w[3:0] = cout_w[3:0];
            default:   w = '0;
        endcase
        return w;
    endfunction

    task automatic post_check(input string name, input logic [31:0] exp, input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
        time_q.push_back($time);
    endtask

    // compare process drains the queued checks on every rising edge
    always @(posedge wb_clk) begin
        while (exp_q.size() != 0) begin
            check_count++;
            if (act_q[0] !== exp_q[0]) begin
                error_count++;
                test_errors++;
                $display("mismatch at %0d ns: %s expected 0x%0h, got 0x%0h",
                         time_q[0], name_q[0], exp_q[0], act_q[0]);
            end
            void'(name_q.pop_front());
            void'(exp_q.pop_front());
            void'(act_q.pop_front());
            void'(time_q.pop_front());
        end
    end

    always @(posedge wb_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // a transfer happens on the next rising edge when both are high here
    always @(negedge wb_clk) begin
        if (runcmd_tvalid && runcmd_tready) runcmd_xfers++;
        if (trig_tvalid && trig_tready) trig_xfers++;
    end

    task automatic bus_access(input logic [5:0] off, input logic we, input logic [3:0] sel,
                              input logic [31:0] wdat, output logic [31:0] data);
        wb_req_t req;
        req.cyc  = 1'b1;
        req.stb  = 1'b1;
        req.we   = we;
        req.adr  = RB_ADDR_BITS'(off);
        req.sel  = sel;
        req.wdat = wdat;
        @(posedge wb_clk);
        bus <= req;
        // ack may only follow one cycle after the request opens
        @(negedge wb_clk);
        post_check("ack_o", 32'h0, 32'(ack));
        while (!ack) @(negedge wb_clk);
        data = rdat;
        // the write commits on this edge, and the cycle ends with it
        @(posedge wb_clk);
        bus <= '0;
    endtask

    task automatic write_reg(input logic [5:0] off, input logic [3:0] sel, input logic [31:0] wdat);
        logic [31:0] ignored;
        bus_access(off, 1'b1, sel, wdat, ignored);
        case (off)
            CONTROL:   ctrl_w = merge_lanes(ctrl_w, wdat, sel);
            LIVE:      live_w = merge_lanes(live_w, wdat, sel);
            TRAININ:   trainin_w = merge_lanes(trainin_w, wdat, sel);
            TRAINCMPL: traincmpl_w = merge_lanes(traincmpl_w, wdat, sel);
            COUTCTRL:  cout_w = merge_lanes(cout_w, wdat, sel);
            RUNCMD: begin
                if (sel[0]) begin
                    runcmd_pend = 1'b1;
                    runcmd_last = wdat[RUNCMD_BITS-1:0];
                end
            end
            TRIG: begin
                if (sel[0] && sel[1]) begin
                    trig_pend = 1'b1;
                    trig_last = wdat[TRIG_BITS-1:0];
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic read_check(input logic [5:0] off);
        logic [31:0] data;
        bus_access(off, 1'b0, 4'h0, '0, data);
        post_check($sformatf("rdat_o at 0x%02h", off), expected_read(off), data);
    endtask

    task automatic check_outputs();
        post_check("event_reset_o", 32'(ctrl_w[16]), 32'(event_reset));
        post_check("disable_rxclk_o", 32'(ctrl_w[31:24]), 32'(disable_rxclk));
        post_check("livedet_reset_o", 32'(live_w[31]), 32'(livedet_reset));
        post_check("cout_offset_o", 32'(cout_w[3:0]), 32'(cout_offset));
        post_check("train_complete_o", 32'(traincmpl_w[6:0]), 32'(train_complete));
        post_check("runcmd_tvalid_o", 32'(runcmd_pend), 32'(runcmd_tvalid));
        post_check("trig_tvalid_o", 32'(trig_pend), 32'(trig_tvalid));
    endtask

    task automatic pulse_tready(input logic on_trig);
        @(posedge wb_clk);
        if (on_trig) trig_tready <= 1'b1;
        else runcmd_tready <= 1'b1;
        @(posedge wb_clk);
        trig_tready   <= 1'b0;
        runcmd_tready <= 1'b0;
        if (on_trig) trig_pend = 1'b0;
        else runcmd_pend = 1'b0;
        @(negedge wb_clk);
        check_outputs();
    endtask

    // a pulse only on armed bits that go from low to high
    task automatic train_step(input surf_mask_t req_new);
        surf_mask_t pulse;
        pulse = req_new & ~status.trainin_req & trainin_w[22:16];
        @(posedge wb_clk);
        status.trainin_req <= req_new;
        @(negedge wb_clk);
        post_check("surf_autotrain_en_o", 32'h0, 32'(autotrain_en));
        @(negedge wb_clk);
        post_check("surf_autotrain_en_o", 32'(pulse), 32'(autotrain_en));
        repeat (3) begin
            @(negedge wb_clk);
            post_check("surf_autotrain_en_o", 32'h0, 32'(autotrain_en));
        end
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0) @(negedge wb_clk);
        $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "wrong", test_errors);
        test_errors = 0;
    endtask

    initial begin
        logic [31:0] data;
        logic [63:0] rnd64;
        bus           = '0;
        status        = '0;
        runcmd_tready = 1'b0;
        trig_tready   = 1'b0;
        ctrl_w        = 32'hFF00_0000;
        live_w        = '0;
        trainin_w     = '0;
        traincmpl_w   = '0;
        cout_w        = 32'd3;
        runcmd_pend   = 1'b0;
        trig_pend     = 1'b0;
        runcmd_last   = '0;
        trig_last     = '0;
        void'($urandom(55));
        @(negedge wb_clk);
        while (reset) @(negedge wb_clk);

        check_outputs();
        post_check("surf_autotrain_en_o", 32'h0, 32'(autotrain_en));
        foreach (READ_ADDRS[i]) read_check(READ_ADDRS[i]);
        end_test("reset values");

        for (int i = 0; i < WRITE_ROUNDS; i++) begin
            data = $urandom();
            write_reg(WRITE_ADDRS[$urandom_range(4, 0)], 4'($urandom()), data);
            @(negedge wb_clk);
            check_outputs();
            foreach (WRITE_ADDRS[j]) read_check(WRITE_ADDRS[j]);
        end
        end_test("register write and readback");

        write_reg(RUNCMD, 4'hF, $urandom());
        @(negedge wb_clk);
        check_outputs();
        post_check("runcmd_tdata_o", 32'(runcmd_last), 32'(runcmd_tdata));
        read_check(CONTROL);
        // lane 1 missing, so this trigger write loads nothing
        write_reg(TRIG, 4'h1, $urandom());
        @(negedge wb_clk);
        check_outputs();
        write_reg(TRIG, 4'h3, $urandom());
        @(negedge wb_clk);
        check_outputs();
        post_check("trig_tdata_o", 32'(trig_last), 32'(trig_tdata));
        write_reg(RUNCMD, 4'h1, $urandom());
        @(negedge wb_clk);
        check_outputs();
        post_check("runcmd_tdata_o", 32'(runcmd_last), 32'(runcmd_tdata));
        read_check(CONTROL);
        pulse_tready(1'b0);
        pulse_tready(1'b1);
        post_check("runcmd transfers", 32'd1, 32'(runcmd_xfers));
        post_check("trig transfers", 32'd1, 32'(trig_xfers));
        read_check(CONTROL);
        end_test("command streams");

        write_reg(TRAININ, 4'b0100, 32'(7'($urandom())) << 16);
        @(negedge wb_clk);
        check_outputs();
        train_step(7'($urandom()));
        train_step(7'($urandom()));
        train_step('1);
        train_step('0);
        train_step(7'($urandom()));
        read_check(TRAININ);
        end_test("autotrain pulses");

        write_reg(LIVE, 4'b1000, 32'h8000_0000);
        write_reg(TRAINCMPL, 4'b0001, $urandom());
        for (int i = 0; i < STATUS_ROUNDS; i++) begin
            rnd64 = {$urandom(), $urandom()};
            @(posedge wb_clk);
            status <= rnd64[34:0];
            read_check(LIVE);
            read_check(TRAININ);
            read_check(TRAINOUT);
            read_check(TRAINCMPL);
        end
        end_test("status readback");

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    localparam real HALF_PERIOD  = 2.0;
    localparam int  RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // reset drops on the rising edge that ends the fifth cycle
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== source/rack_register_core.sv ====
`timescale 1ns/1ps

module rack_register_core
    import rackbus_pkg::*, surf_pkg::*;
(
    input  logic                         wb_clk_i,
    input  logic                         reset_i,
    input  wb_req_t                      bus_i,
    input  surf_status_t                 status_i,
    input  logic                         runcmd_tready_i,
    input  logic                         trig_tready_i,
    output logic                         ack_o,
    output logic [RB_DATA_BITS-1:0]      rdat_o,
    output logic                         runcmd_tvalid_o,
    output logic [RUNCMD_BITS-1:0]       runcmd_tdata_o,
    output logic                         trig_tvalid_o,
    output logic [TRIG_BITS-1:0]         trig_tdata_o,
    output logic                         event_reset_o,
    output logic                         livedet_reset_o,
    output logic [CTRL_DISABLE_BITS-1:0] disable_rxclk_o,
    output logic [COUT_OFFSET_BITS-1:0]  cout_offset_o,
    output surf_mask_t                   train_complete_o,
    output surf_mask_t                   surf_autotrain_en_o
);

    logic                 runcmd_load;
    logic                 trig_load;
    logic [TRIG_BITS-1:0] cmd_data;

    reg_bank u_reg_bank (
        .wb_clk_i            (wb_clk_i),
        .reset_i             (reset_i),
        .bus_i               (bus_i),
        .status_i            (status_i),
        .runcmd_busy_i       (runcmd_tvalid_o),
        .trig_busy_i         (trig_tvalid_o),
        .ack_o               (ack_o),
        .rdat_o              (rdat_o),
        .runcmd_load_o       (runcmd_load),
        .trig_load_o         (trig_load),
        .cmd_data_o          (cmd_data),
        .event_reset_o       (event_reset_o),
        .livedet_reset_o     (livedet_reset_o),
        .disable_rxclk_o     (disable_rxclk_o),
        .cout_offset_o       (cout_offset_o),
        .train_complete_o    (train_complete_o),
        .surf_autotrain_en_o (surf_autotrain_en_o)
    );

    // run commands only use the low bits of the shared command data
    cmd_holding #(
        .WIDTH (RUNCMD_BITS)
    ) u_runcmd_hold (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .load_i   (runcmd_load),
        .data_i   (cmd_data[RUNCMD_BITS-1:0]),
        .tready_i (runcmd_tready_i),
        .tvalid_o (runcmd_tvalid_o),
        .tdata_o  (runcmd_tdata_o)
    );

    cmd_holding #(
        .WIDTH (TRIG_BITS)
    ) u_trig_hold (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .load_i   (trig_load),
        .data_i   (cmd_data),
        .tready_i (trig_tready_i),
        .tvalid_o (trig_tvalid_o),
        .tdata_o  (trig_tdata_o)
    );

endmodule

// ==== source/reg_bank.sv ====
`timescale 1ns/1ps

module reg_bank
    import rackbus_pkg::*, surf_pkg::*;
(
    input  logic                         wb_clk_i,
    input  logic                         reset_i,
    input  wb_req_t                      bus_i,
    input  surf_status_t                 status_i,
    input  logic                         runcmd_busy_i,
    input  logic                         trig_busy_i,
    output logic                         ack_o,
    output logic [RB_DATA_BITS-1:0]      rdat_o,
    output logic                         runcmd_load_o,
    output logic                         trig_load_o,
    output logic [TRIG_BITS-1:0]         cmd_data_o,
    output logic                         event_reset_o,
    output logic                         livedet_reset_o,
    output logic [CTRL_DISABLE_BITS-1:0] disable_rxclk_o,
    output logic [COUT_OFFSET_BITS-1:0]  cout_offset_o,
    output surf_mask_t                   train_complete_o,
    output surf_mask_t                   surf_autotrain_en_o
);

    logic                         ack_q;
    logic [RB_DECODE_BITS-1:0]    word_adr;
    logic                         wr_en;
    logic                         event_reset_q;
    logic                         livedet_reset_q;
    logic [CTRL_DISABLE_BITS-1:0] disable_rxclk_q;
    logic [COUT_OFFSET_BITS-1:0]  cout_offset_q;
    surf_mask_t                   autotrain_q;
    surf_mask_t                   train_complete_q;
    surf_mask_t                   trainin_prev_q;
    surf_mask_t                   autotrain_pulse_q;

    assign word_adr = bus_i.adr[RB_DECODE_BITS-1:0];

    // ack follows one cycle behind cyc and stb and drops as soon as the master
    // ends the cycle
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_i.cyc && bus_i.stb;
        end
    end

    assign ack_o = ack_q && bus_i.cyc;

    // a write commits on the acknowledged edge
    assign wr_en = bus_i.cyc && bus_i.stb && bus_i.we && ack_o;

    // runcmd needs lane 0, the trigger needs both low lanes
    assign runcmd_load_o = wr_en && (word_adr == RUNCMD) && bus_i.sel[0];
    assign trig_load_o   = wr_en && (word_adr == TRIG) && bus_i.sel[0] && bus_i.sel[1];
    assign cmd_data_o    = bus_i.wdat[TRIG_BITS-1:0];

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            event_reset_q    <= 1'b0;
            livedet_reset_q  <= 1'b0;
            disable_rxclk_q  <= DISABLE_RXCLK_DEFAULT;
            cout_offset_q    <= COUT_OFFSET_DEFAULT;
            autotrain_q      <= '0;
            train_complete_q <= '0;
        end else if (wr_en) begin
            case (word_adr)
                CONTROL: begin
                    if (bus_i.sel[CTRL_EVENT_RESET_BIT/8]) begin
                        event_reset_q <= bus_i.wdat[CTRL_EVENT_RESET_BIT];
                    end
                    if (bus_i.sel[CTRL_DISABLE_LSB/8]) begin
                        disable_rxclk_q <= bus_i.wdat[CTRL_DISABLE_LSB +: CTRL_DISABLE_BITS];
                    end
                end
                LIVE: begin
                    if (bus_i.sel[LIVEDET_RESET_BIT/8]) begin
                        livedet_reset_q <= bus_i.wdat[LIVEDET_RESET_BIT];
                    end
                end
                TRAININ: begin
                    // autotrain enables share the word with the request flags
                    if (bus_i.sel[STATUS_HIGH_LSB/8]) begin
                        autotrain_q <= bus_i.wdat[STATUS_HIGH_LSB +: NUM_SURF];
                    end
                end
                TRAINCMPL: begin
                    if (bus_i.sel[0]) begin
                        train_complete_q <= bus_i.wdat[NUM_SURF-1:0];
                    end
                end
                COUTCTRL: begin
                    if (bus_i.sel[0]) begin
                        cout_offset_q <= bus_i.wdat[COUT_OFFSET_BITS-1:0];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // an armed SURF gets a single pulse when its training request rises
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            trainin_prev_q    <= '0;
            autotrain_pulse_q <= '0;
        end else begin
            trainin_prev_q    <= status_i.trainin_req;
            autotrain_pulse_q <= status_i.trainin_req & ~trainin_prev_q & autotrain_q;
        end
    end

    // readback words are built from the registers and the live detector flags
    always_comb begin
        rdat_o = '0;
        case (word_adr)
            CONTROL: begin
                rdat_o[CTRL_DISABLE_LSB +: CTRL_DISABLE_BITS] = disable_rxclk_q;
                rdat_o[CTRL_EVENT_RESET_BIT] = event_reset_q;
                // idle bits read high when nothing waits on the stream
                rdat_o[CTRL_TRIG_IDLE_BIT]   = !trig_busy_i;
                rdat_o[CTRL_RUNCMD_IDLE_BIT] = !runcmd_busy_i;
            end
            LIVE: begin
                rdat_o[LIVEDET_RESET_BIT] = livedet_reset_q;
                rdat_o[STATUS_HIGH_LSB +: NUM_SURF] = status_i.misaligned;
                rdat_o[NUM_SURF-1:0] = status_i.live;
            end
            TRAININ: begin
                rdat_o[STATUS_HIGH_LSB +: NUM_SURF] = autotrain_q;
                rdat_o[NUM_SURF-1:0] = status_i.trainin_req;
            end
            TRAINOUT: begin
                rdat_o[NUM_SURF-1:0] = status_i.trainout_rdy;
            end
            TRAINCMPL: begin
                rdat_o[STATUS_HIGH_LSB +: NUM_SURF] = status_i.boot_seen;
                rdat_o[NUM_SURF-1:0] = train_complete_q;
            end
            COUTCTRL: begin
                rdat_o[COUT_OFFSET_BITS-1:0] = cout_offset_q;
            end
            default: begin
                rdat_o = '0;
            end
        endcase
    end

    assign event_reset_o       = event_reset_q;
    assign livedet_reset_o     = livedet_reset_q;
    assign disable_rxclk_o     = disable_rxclk_q;
    assign cout_offset_o       = cout_offset_q;
    assign train_complete_o    = train_complete_q;
    assign surf_autotrain_en_o = autotrain_pulse_q;

    // an ack is only given while the master still holds both cyc and stb
    ack_needs_cycle: assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        ack_o |-> bus_i.cyc && bus_i.stb
    );

    // an autotrain pulse never stays high on two consecutive cycles
    autotrain_single_cycle: assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        (surf_autotrain_en_o & $past(surf_autotrain_en_o)) == '0
    );

endmodule

// ==== source/cmd_holding.sv ====
`timescale 1ns/1ps

module cmd_holding
    import rackbus_pkg::*, surf_pkg::*;
#(
    parameter int WIDTH = TRIG_BITS
) (
    input  logic             wb_clk_i,
    input  logic             reset_i,
    input  logic             load_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             tready_i,
    output logic             tvalid_o,
    output logic [WIDTH-1:0] tdata_o
);

    logic             tvalid_q;
    logic [WIDTH-1:0] tdata_q;

    // the command is loaded straight from one bus data word
    if (WIDTH > RB_DATA_BITS) begin : g_width_check
        $error("cmd_holding WIDTH exceeds the bus data width");
    end

    // a new load wins over a transfer in the same cycle
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            tvalid_q <= 1'b0;
        end else if (load_i) begin
            tvalid_q <= 1'b1;
        end else if (tready_i) begin
            tvalid_q <= 1'b0;
        end
    end

    // a pending command is simply overwritten by a newer one
    always_ff @(posedge wb_clk_i) begin
        if (load_i) begin
            tdata_q <= data_i;
        end
    end

    assign tvalid_o = tvalid_q;
    assign tdata_o  = tdata_q;

    // back-pressure keeps the command parked unchanged
    hold_under_backpressure: assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        tvalid_o && !tready_i && !load_i |=> tvalid_o && $stable(tdata_o)
    );

endmodule

// ==== source/surf_pkg.sv ====
package surf_pkg;

    // number of SURF links served by one rack controller
    localparam int NUM_SURF = 7;

    // command word widths on the two outgoing streams
    localparam int RUNCMD_BITS = 2;
    localparam int TRIG_BITS   = 15;

    typedef logic [NUM_SURF-1:0] surf_mask_t;

    // per-SURF flags reported by the live detector
    typedef struct packed {
        surf_mask_t live;
        surf_mask_t misaligned;
        surf_mask_t boot_seen;
        // the SURF asks for training on its input links
        surf_mask_t trainin_req;
        // the SURF has put its own outputs into training
        surf_mask_t trainout_rdy;
    } surf_status_t;

endpackage

// ==== source/rackbus_pkg.sv ====
package rackbus_pkg;

    // host bus widths
    localparam int RB_ADDR_BITS   = 10;
    localparam int RB_DATA_BITS   = 32;
    localparam int RB_SEL_BITS    = RB_DATA_BITS / 8;
    // only the low address bits take part in the register decode
    localparam int RB_DECODE_BITS = 6;

    typedef enum logic [RB_DECODE_BITS-1:0] {
        CONTROL   = 6'h00,
        RUNCMD    = 6'h08,
        TRIG      = 6'h0C,
        LIVE      = 6'h10,
        TRAININ   = 6'h14,
        TRAINOUT  = 6'h18,
        TRAINCMPL = 6'h1C,
        COUTCTRL  = 6'h20
    } reg_addr_e;

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [RB_ADDR_BITS-1:0] adr;
        logic [RB_SEL_BITS-1:0]  sel;
        logic [RB_DATA_BITS-1:0] wdat;
    } wb_req_t;

    // bit positions inside the 32-bit register words
    localparam int CTRL_RUNCMD_IDLE_BIT = 2;
    localparam int CTRL_TRIG_IDLE_BIT   = 3;
    localparam int CTRL_EVENT_RESET_BIT = 16;
    localparam int CTRL_DISABLE_LSB     = 24;
    localparam int CTRL_DISABLE_BITS    = 8;
    localparam int STATUS_HIGH_LSB      = 16;
    localparam int LIVEDET_RESET_BIT    = 31;
    localparam int COUT_OFFSET_BITS     = 4;

    localparam logic [COUT_OFFSET_BITS-1:0]  COUT_OFFSET_DEFAULT   = 4'd3;
    localparam logic [CTRL_DISABLE_BITS-1:0] DISABLE_RXCLK_DEFAULT = 8'hFF;

endpackage
